//--- verilog/rv_isa_pkg.sv
// ============================
// rv32i instruction set types
// ============================
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [3:0]      wmask_t;   // one bit per byte lane

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_system = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        type_r,
        type_i,
        type_s,
        type_b,
        type_u,
        type_j,
        type_none   // not decoded
    } inst_type_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // load and store sizes
    localparam funct3_t f3_byte   = 3'b000;
    localparam funct3_t f3_half   = 3'b001;
    localparam funct3_t f3_word   = 3'b010;
    localparam funct3_t f3_byte_u = 3'b100;
    localparam funct3_t f3_half_u = 3'b101;

    localparam word_t ebreak_imm = 32'd1;

endpackage

`default_nettype wire

//--- verilog/rv_core_pkg.sv
// ============================
// core control definitions
// ============================
`default_nettype none

package rv_core_pkg;

    // one instruction in flight, so one state per phase
    typedef enum logic [2:0] {
        fetch_req,
        fetch_wait,
        execute,
        mem_req,
        mem_wait,
        writeback,
        halt
    } core_state_t;

    localparam logic [31:0] reset_pc = 32'h8000_0000;

endpackage

`default_nettype wire

//--- verilog/rv_decode_if.sv
// ============================
// decoded instruction bundle
// ============================
`default_nettype none

interface rv_decode_if import rv_isa_pkg::*; ();

    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm;
    funct3_t    funct3;
    opcode_t    opcode;
    inst_type_t inst_type;
    alu_op_t    alu_op;

    modport decoder (output rd, rs1, rs2, imm, funct3, opcode, inst_type, alu_op);
    modport execute (input rd, rs1, rs2, imm, funct3, opcode, inst_type, alu_op);
    modport lsu     (input rd, rs1, rs2, imm, funct3, opcode, inst_type, alu_op);
    modport control (input rd, rs1, rs2, imm, funct3, opcode, inst_type, alu_op);

endinterface

`default_nettype wire

//--- verilog/rv_sequencer.sv
// ============================
// core control sequencer
// ============================
`default_nettype none

module rv_sequencer import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           fetch_req_ready,
    input  logic           fetch_resp_valid,
    input  logic           data_req_ready,
    input  logic           data_resp_valid,
    input  logic           is_mem,
    rv_decode_if.control   dec,
    output logic           fetch_req_valid,
    output logic           fetch_resp_ready,
    output logic           ir_load,
    output logic           pc_load,
    output logic           mem_start,
    output logic           mem_active,
    output logic           data_resp_ready,
    output logic           mem_capture,
    output logic           wb_en,
    output logic           retire_valid,
    output logic           halted,
    output logic           illegal
);

    core_state_t state;
    core_state_t next_state;
    logic        started;   // low for the cycle right after reset
    logic        is_ebreak;
    logic        stop;

    assign is_ebreak = dec.opcode == opc_system && dec.inst_type == type_i
                       && dec.imm == ebreak_imm;
    assign stop = is_ebreak || dec.inst_type == type_none;

    always_comb begin
        next_state = state;
        case (state)
            fetch_req:  if (fetch_req_valid && fetch_req_ready) next_state = fetch_wait;
            fetch_wait: if (fetch_resp_valid) next_state = execute;
            execute: begin
                if (stop) begin
                    next_state = halt;
                end else if (is_mem) begin
                    next_state = mem_req;
                end else begin
                    next_state = writeback;
                end
            end
            mem_req:    if (data_req_ready) next_state = mem_wait;
            mem_wait:   if (data_resp_valid) next_state = writeback;
            writeback:  next_state = fetch_req;
            default:    next_state = halt;   // only reset leaves halt
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= fetch_req;
            started <= 1'b0;
            illegal <= 1'b0;
        end else begin
            state   <= next_state;
            started <= 1'b1;
            if (state == execute && dec.inst_type == type_none) begin
                illegal <= 1'b1;
            end
        end
    end

    assign fetch_req_valid  = state == fetch_req && started;
    assign fetch_resp_ready = state == fetch_wait;
    assign ir_load          = state == fetch_wait && fetch_resp_valid;
    assign mem_start        = state == execute && is_mem && !stop;
    assign mem_active       = state == mem_req;
    assign data_resp_ready  = state == mem_wait;
    assign mem_capture      = state == mem_wait && data_resp_valid;
    assign pc_load          = state == writeback;
    assign retire_valid     = state == writeback;
    assign halted           = state == halt;
    // branches and stores leave the register file alone
    assign wb_en = state == writeback
                   && dec.inst_type inside {type_r, type_i, type_u, type_j};

    assert property (@(posedge clk) disable iff (reset)
        fetch_req_valid && !fetch_req_ready |=> fetch_req_valid);

    assert property (@(posedge clk) disable iff (reset)
        halted |=> halted && !retire_valid);

endmodule

`default_nettype wire

//--- verilog/rv_fetch.sv
// ============================
// program counter and fetch
// ============================
`default_nettype none

module rv_fetch import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  pc_load,
    input  logic  ir_load,
    input  word_t fetch_data,
    input  logic  jump_en,
    input  word_t jump_target,
    output word_t pc,
    output word_t snpc,
    output word_t fetch_addr,
    output word_t inst
);

    assign snpc       = pc + 32'd4;
    assign fetch_addr = pc;   // steady until writeback

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (pc_load) begin
            pc <= jump_en ? jump_target : snpc;
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (ir_load) begin
            inst <= fetch_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_decoder.sv
// ============================
// rv32i instruction decoder
// ============================
`default_nettype none

module rv_decoder import rv_isa_pkg::*; (
    input  word_t         inst,
    rv_decode_if.decoder  dec
);

    logic [6:0] funct7;

    assign funct7     = inst[31:25];
    assign dec.opcode = opcode_t'(inst[6:0]);
    assign dec.funct3 = inst[14:12];
    assign dec.rd     = inst[11:7];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = inst[24:20];

    // unused funct3 codes fall to type_none
    always_comb begin
        case (dec.opcode)
            opc_op:               dec.inst_type = type_r;
            opc_op_imm, opc_jalr: dec.inst_type = type_i;
            opc_load:   dec.inst_type = dec.funct3 inside {3'b011, 3'b110, 3'b111}
                                        ? type_none : type_i;
            opc_store:  dec.inst_type = dec.funct3 > f3_word ? type_none : type_s;
            opc_branch: dec.inst_type = dec.funct3 inside {3'b010, 3'b011}
                                        ? type_none : type_b;
            opc_lui, opc_auipc:   dec.inst_type = type_u;
            opc_jal:              dec.inst_type = type_j;
            opc_system: dec.inst_type = inst[31:7] == 25'h0002000 ? type_i : type_none;
            default:              dec.inst_type = type_none;
        endcase
    end

    always_comb begin
        case (dec.inst_type)
            type_i:  dec.imm = {{20{inst[31]}}, inst[31:20]};
            type_s:  dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            type_b:  dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            type_u:  dec.imm = {inst[31:12], 12'b0};
            type_j:  dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: dec.imm = '0;
        endcase
    end

    always_comb begin
        dec.alu_op = alu_add;   // address and link sums
        if (dec.inst_type == type_r || dec.opcode == opc_op_imm) begin
            case (dec.funct3)
                3'b000:  dec.alu_op = (dec.inst_type == type_r && funct7[5]) ? alu_sub : alu_add;
                3'b001:  dec.alu_op = alu_sll;
                3'b010:  dec.alu_op = alu_slt;
                3'b011:  dec.alu_op = alu_sltu;
                3'b100:  dec.alu_op = alu_xor;
                3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;
                3'b110:  dec.alu_op = alu_or;
                default: dec.alu_op = alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_regfile.sv
// ============================
// general register file
// ============================
`default_nettype none

module rv_regfile import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  reg_addr_t waddr,
    input  logic      wen,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wen && waddr != '0) begin   // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    assert property (@(posedge clk) disable iff (reset) wen |-> !$isunknown(wdata));

endmodule

`default_nettype wire

//--- verilog/rv_execute.sv
// ============================
// alu, branch and writeback
// ============================
`default_nettype none

module rv_execute import rv_isa_pkg::*; (
    rv_decode_if.execute dec,
    input  word_t        pc,
    input  word_t        snpc,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    input  word_t        load_data,
    output word_t        alu_result,
    output word_t        jump_target,
    output word_t        wb_data,
    output logic         jump_en,
    output logic         wb_we,
    output logic         is_mem
);

    word_t op_a;
    word_t op_b;
    logic  take_branch;
    logic  is_jalr;

    // i and s types keep rs1 + imm
    always_comb begin
        op_a = rs1_data;
        op_b = dec.imm;
        case (dec.inst_type)
            type_r:         op_b = rs2_data;
            type_b, type_j: op_a = pc;
            type_u:         op_a = (dec.opcode == opc_lui) ? '0 : pc;
            default: ;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << op_b[4:0];
            alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {31'b0, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> op_b[4:0];
            alu_sra:  alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            f3_beq:  take_branch = rs1_data == rs2_data;
            f3_bne:  take_branch = rs1_data != rs2_data;
            f3_blt:  take_branch = $signed(rs1_data) < $signed(rs2_data);
            f3_bge:  take_branch = $signed(rs1_data) >= $signed(rs2_data);
            f3_bltu: take_branch = rs1_data < rs2_data;
            f3_bgeu: take_branch = rs1_data >= rs2_data;
            default: take_branch = 1'b0;
        endcase
    end

    assign is_jalr     = dec.opcode == opc_jalr;
    assign jump_en     = dec.inst_type == type_j || is_jalr
                         || (dec.inst_type == type_b && take_branch);
    assign jump_target = is_jalr ? {alu_result[31:1], 1'b0} : alu_result;

    assign is_mem  = dec.opcode == opc_load || dec.opcode == opc_store;
    assign wb_we   = dec.inst_type inside {type_r, type_i, type_u, type_j};
    assign wb_data = (dec.inst_type == type_j || is_jalr) ? snpc
                   : (dec.opcode == opc_load) ? load_data : alu_result;

endmodule

`default_nettype wire

//--- verilog/rv_lsu.sv
// ============================
// load and store unit
// ============================
`default_nettype none

module rv_lsu import rv_isa_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    rv_decode_if.lsu    dec,
    input  logic        mem_start,
    input  logic        mem_active,
    input  logic        mem_capture,
    input  word_t       alu_result,
    input  word_t       rs2_data,
    input  word_t       data_rdata,
    output logic        data_req_valid,
    output logic        data_we,
    output word_t       data_addr,
    output word_t       data_wdata,
    output wmask_t      data_wmask,
    output word_t       load_data
);

    wmask_t size_mask;
    word_t  rdata_shifted;

    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   size_mask = 4'b0001;
            2'b01:   size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    // request fields latched once, steady while the port stalls
    always_ff @(posedge clk) begin
        if (mem_start) begin
            data_addr  <= alu_result;
            data_we    <= dec.opcode == opc_store;
            data_wdata <= rs2_data << {alu_result[1:0], 3'b000};
            data_wmask <= size_mask << alu_result[1:0];
        end
    end

    assign data_req_valid = mem_active;
    assign rdata_shifted  = data_rdata >> {data_addr[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (mem_capture) begin
            case (dec.funct3)
                f3_byte:   load_data <= {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
                f3_half:   load_data <= {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
                f3_byte_u: load_data <= {24'b0, rdata_shifted[7:0]};
                f3_half_u: load_data <= {16'b0, rdata_shifted[15:0]};
                default:   load_data <= data_rdata;
            endcase
        end
    end

    // a request only opens right after execute hands over
    assert property (@(posedge clk) disable iff (reset)
        $rose(data_req_valid) |-> $past(mem_start));

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// ============================
// rv32i core top level
// ============================
`default_nettype none

module rv_core import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fetch_req_ready,
    input  logic      fetch_resp_valid,
    input  word_t     fetch_data,
    input  logic      data_req_ready,
    input  logic      data_resp_valid,
    input  word_t     data_rdata,
    output logic      fetch_req_valid,
    output word_t     fetch_addr,
    output logic      fetch_resp_ready,
    output logic      data_req_valid,
    output logic      data_we,
    output word_t     data_addr,
    output word_t     data_wdata,
    output wmask_t    data_wmask,
    output logic      data_resp_ready,
    output logic      retire_valid,
    output word_t     retire_pc,
    output logic      retire_we,
    output reg_addr_t retire_rd,
    output word_t     retire_wdata,
    output logic      halted,
    output logic      illegal
);

    word_t pc;
    word_t snpc;
    word_t inst;
    word_t jump_target;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    word_t wb_data;
    word_t load_data;
    logic  jump_en;
    logic  wb_we;
    logic  is_mem;
    logic  pc_load;
    logic  ir_load;
    logic  mem_start;
    logic  mem_active;
    logic  mem_capture;
    logic  wb_en;

    rv_decode_if dec ();

    assign retire_pc    = pc;
    assign retire_we    = wb_we;
    assign retire_rd    = dec.rd;
    assign retire_wdata = wb_data;

    rv_sequencer u_sequencer (
        .clk              (clk),
        .reset            (reset),
        .fetch_req_ready  (fetch_req_ready),
        .fetch_resp_valid (fetch_resp_valid),
        .data_req_ready   (data_req_ready),
        .data_resp_valid  (data_resp_valid),
        .is_mem           (is_mem),
        .dec              (dec.control),
        .fetch_req_valid  (fetch_req_valid),
        .fetch_resp_ready (fetch_resp_ready),
        .ir_load          (ir_load),
        .pc_load          (pc_load),
        .mem_start        (mem_start),
        .mem_active       (mem_active),
        .data_resp_ready  (data_resp_ready),
        .mem_capture      (mem_capture),
        .wb_en            (wb_en),
        .retire_valid     (retire_valid),
        .halted           (halted),
        .illegal          (illegal)
    );

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .pc_load     (pc_load),
        .ir_load     (ir_load),
        .fetch_data  (fetch_data),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc),
        .fetch_addr  (fetch_addr),
        .inst        (inst)
    );

    rv_decoder u_decoder (
        .inst (inst),
        .dec  (dec.decoder)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .waddr  (dec.rd),
        .wen    (wb_en),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    rv_execute u_execute (
        .dec         (dec.execute),
        .pc          (pc),
        .snpc        (snpc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .load_data   (load_data),
        .alu_result  (alu_result),
        .jump_target (jump_target),
        .wb_data     (wb_data),
        .jump_en     (jump_en),
        .wb_we       (wb_we),
        .is_mem      (is_mem)
    );

    rv_lsu u_lsu (
        .clk            (clk),
        .reset          (reset),
        .dec            (dec.lsu),
        .mem_start      (mem_start),
        .mem_active     (mem_active),
        .mem_capture    (mem_capture),
        .alu_result     (alu_result),
        .rs2_data       (rs2_data),
        .data_rdata     (data_rdata),
        .data_req_valid (data_req_valid),
        .data_we        (data_we),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_wmask     (data_wmask),
        .load_data      (load_data)
    );

endmodule

`default_nettype wire

//--- verification/rv_core_tb.sv
// ============================
// rv32i core testbench
// ============================
`default_nettype none

module rv_core_tb import rv_isa_pkg::*, rv_core_pkg::*; ();

    localparam int max_words = 64;

    logic      clk;
    logic      reset;
    logic      fetch_req_ready;
    logic      fetch_resp_valid;
    word_t     fetch_data;
    logic      data_req_ready;
    logic      data_resp_valid;
    word_t     data_rdata;
    logic      fetch_req_valid;
    word_t     fetch_addr;
    logic      fetch_resp_ready;
    logic      data_req_valid;
    logic      data_we;
    word_t     data_addr;
    word_t     data_wdata;
    wmask_t    data_wmask;
    logic      data_resp_ready;
    logic      retire_valid;
    word_t     retire_pc;
    logic      retire_we;
    reg_addr_t retire_rd;
    word_t     retire_wdata;
    logic      halted;
    logic      illegal;

    // vectors, per program
    int        num_progs;
    word_t     prog_mem [2][max_words];
    int        prog_len [2];
    word_t     init_addr [2][max_words];
    word_t     init_data [2][max_words];
    int        init_cnt [2];
    word_t     rec_pc [2][max_words];
    logic      rec_we [2][max_words];
    reg_addr_t rec_rd [2][max_words];
    word_t     rec_data [2][max_words];
    int        rec_cnt [2];
    logic      exp_halted [2];
    logic      exp_illegal [2];
    logic      loaded;

    word_t     data_mem [word_t];
    word_t     lfsr;
    int        cur_prog;
    int        rec_idx;
    int        checks;
    int        errors;

    // memory model state
    logic      f_pending;
    word_t     f_addr;
    int        f_delay;
    logic      d_pending;
    word_t     d_word;
    int        d_delay;

    rv_core u_dut (.*);

    always #10 clk = ~clk;

    function automatic word_t lfsr_next(word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int r);
        r = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic word_t prog_word(word_t addr);
        word_t idx;
        idx = (addr - reset_pc) >> 2;
        if (addr >= reset_pc && idx < word_t'(prog_len[cur_prog])) begin
            return prog_mem[cur_prog][idx];
        end
        return {addr[31:7] ^ addr[24:0], 7'h7f};   // never decodes
    endfunction

    function automatic word_t read_data(word_t addr);
        if (data_mem.exists(addr)) begin
            return data_mem[addr];
        end
        return addr ^ 32'h5a5a_c3c3;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s expected x%0d actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_halt(input string name, input logic exp_h, input logic exp_i);
        checks++;
        if (exp_h !== halted || exp_i !== illegal) begin
            errors++;
            $display("error %s expected halted=%b illegal=%b actual halted=%b illegal=%b",
                     name, exp_h, exp_i, halted, illegal);
        end
    endtask

    task automatic load_vectors(output logic opened);
        int    fd;
        byte   tag;
        string line;
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        num_progs = 0;
        fd = $fopen("verification/rv_core_vectors.txt", "r");
        opened = fd != 0;
        if (opened) begin
            while ($fgets(line, fd) > 0) begin
                tag = line.getc(0);
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
                case (tag)
                    "s": begin
                        num_progs++;
                        prog_len[num_progs-1] = 0;
                        init_cnt[num_progs-1] = 0;
                        rec_cnt[num_progs-1] = 0;
                    end
                    "i": begin
                        prog_mem[num_progs-1][prog_len[num_progs-1]] = a;
                        prog_len[num_progs-1]++;
                    end
                    "m": begin
                        init_addr[num_progs-1][init_cnt[num_progs-1]] = a;
                        init_data[num_progs-1][init_cnt[num_progs-1]] = b;
                        init_cnt[num_progs-1]++;
                    end
                    "r": begin
                        rec_pc[num_progs-1][rec_cnt[num_progs-1]] = a;
                        rec_we[num_progs-1][rec_cnt[num_progs-1]] = b[0];
                        rec_rd[num_progs-1][rec_cnt[num_progs-1]] = c[4:0];
                        rec_data[num_progs-1][rec_cnt[num_progs-1]] = d;
                        rec_cnt[num_progs-1]++;
                    end
                    "h": begin
                        exp_halted[num_progs-1] = a[0];
                        exp_illegal[num_progs-1] = b[0];
                    end
                    default: ;   // comments and blank lines
                endcase
            end
            $fclose(fd);
        end
    endtask

    // handshakes seen at the rising edge
    always @(posedge clk) begin
        if (reset) begin
            f_pending = 1'b0;
            d_pending = 1'b0;
        end else begin
            if (fetch_resp_valid && fetch_resp_ready) f_pending = 1'b0;
            if (fetch_req_valid && fetch_req_ready) begin
                f_pending = 1'b1;
                f_addr = fetch_addr;
                rand_bits(2, f_delay);
            end
            if (data_resp_valid && data_resp_ready) d_pending = 1'b0;
            if (data_req_valid && data_req_ready) begin
                d_word = read_data({data_addr[31:2], 2'b00});
                if (data_we) begin
                    for (int k = 0; k < 4; k++) begin
                        if (data_wmask[k]) d_word[k*8 +: 8] = data_wdata[k*8 +: 8];
                    end
                    data_mem[{data_addr[31:2], 2'b00}] = d_word;
                    d_word = '0;   // store response has no data
                end
                d_pending = 1'b1;
                rand_bits(2, d_delay);
            end
        end
    end

    // both memories drive on the falling edge
    always @(negedge clk) begin
        int r;
        rand_bits(2, r);
        fetch_req_ready = r != 0;
        rand_bits(2, r);
        data_req_ready = r != 0;
        fetch_resp_valid = 1'b0;
        if (f_pending) begin
            if (f_delay == 0) begin
                fetch_resp_valid = 1'b1;
                fetch_data = prog_word(f_addr);
            end else begin
                f_delay--;
            end
        end
        data_resp_valid = 1'b0;
        if (d_pending) begin
            if (d_delay == 0) begin
                data_resp_valid = 1'b1;
                data_rdata = d_word;
            end else begin
                d_delay--;
            end
        end
    end

    // retire trace against the records
    always @(posedge clk) begin
        if (!reset && retire_valid) begin
            if (rec_idx >= rec_cnt[cur_prog]) begin
                errors++;
                $display("unexpected retire at pc %h after the last record", retire_pc);
            end else begin
                check_word($sformatf("retire %0d pc", rec_idx), rec_pc[cur_prog][rec_idx],
                           retire_pc);
                check_bit($sformatf("retire %0d we", rec_idx), rec_we[cur_prog][rec_idx],
                          retire_we);
                if (rec_we[cur_prog][rec_idx]) begin
                    check_reg($sformatf("retire %0d rd", rec_idx),
                              rec_rd[cur_prog][rec_idx], retire_rd);
                    check_word($sformatf("retire %0d data", rec_idx),
                               rec_data[cur_prog][rec_idx], retire_wdata);
                end
            end
            rec_idx++;
        end
    end

    task automatic run_program(input int p);
        int fetches;
        int errors_before;
        errors_before = errors;
        fetches = 0;
        @(negedge clk);
        reset = 1'b1;
        cur_prog = p;
        rec_idx = 0;
        data_mem.delete();
        for (int k = 0; k < init_cnt[p]; k++) begin
            data_mem[init_addr[p][k]] = init_data[p][k];
        end
        repeat (4) @(posedge clk);
        check_bit("outputs idle in reset", 1'b0, fetch_req_valid | data_req_valid
                  | retire_valid | halted | illegal);
        @(negedge clk);
        reset = 1'b0;
        while (!halted) @(posedge clk);
        repeat (10) begin
            @(posedge clk);
            if (fetch_req_valid) fetches++;
        end
        check_halt($sformatf("program %0d halt", p), exp_halted[p], exp_illegal[p]);
        if (fetches != 0) begin
            errors++;
            $display("program %0d kept requesting fetches after halt", p);
        end
        if (rec_idx < rec_cnt[p]) begin
            errors++;
            $display("program %0d halted early after %0d of %0d retires", p, rec_idx,
                     rec_cnt[p]);
        end
        $display("program %0d: %0d retires, %0d errors", p, rec_idx, errors - errors_before);
    endtask

    // watchdog scaled by the trace length
    initial begin
        int total;
        wait (loaded);
        total = 0;
        for (int p = 0; p < num_progs; p++) total += rec_cnt[p];
        repeat (total * 200) @(posedge clk);
        $display("watchdog expired before the programs finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic opened;
        clk = 1'b0;
        reset = 1'b1;
        fetch_req_ready = 1'b0;
        fetch_resp_valid = 1'b0;
        fetch_data = '0;
        data_req_ready = 1'b0;
        data_resp_valid = 1'b0;
        data_rdata = '0;
        lfsr = 32'h10f70631;
        cur_prog = 0;
        rec_idx = 0;
        checks = 0;
        errors = 0;
        f_pending = 1'b0;
        d_pending = 1'b0;
        f_delay = 0;
        d_delay = 0;
        loaded = 1'b0;
        load_vectors(opened);
        if (!opened) begin
            $display("could not open the vector file");
            $display("TEST FAIL");
        end else begin
            loaded = 1'b1;
            for (int p = 0; p < num_progs; p++) run_program(p);
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_core.f
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_decode_if.sv
verilog/rv_sequencer.sv
verilog/rv_fetch.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
verification/rv_core_tb.sv

//--- Makefile
# Verilator build for the rv32i core testbench

TOP := rv_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f rv_core.f --top-module $(TOP)

obj_dir/V$(TOP): rv_core.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -f rv_core.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/rv_core_vectors.txt
# s: new program | i: word | m: addr word | r: pc we rd data | h: halted illegal
# words are hex, program words start at the reset pc
s
i 00500093
i ffd00113
i 002081b3
i 40208233
i 00309293
i 40115313
i 01c15393
i 00112433
i 001134b3
i 0ff0c513
i 0020e5b3
i 00f17613
i 00708013
i 001006b3
i 00001737
i 00000797
i 00272023
i 001702a3
i 00271323
i 00072803
i 00670883
i 00774903
i 00671983
i 00475a03
i 00872a83
i 00d08463
i 00100b13
i 00d09463
i 00114463
i 00100b13
i 00115463
i 00116463
i 00117463
i 00100b13
i 00800bef
i 00100b13
i 00000c17
i 00dc0ce7
i 00100b13
i 00100073
m 00001000 deadbeef
m 00001004 11223344
m 00001008 80706050
r 80000000 1 01 00000005
r 80000004 1 02 fffffffd
r 80000008 1 03 00000002
r 8000000c 1 04 00000008
r 80000010 1 05 00000028
r 80000014 1 06 fffffffe
r 80000018 1 07 0000000f
r 8000001c 1 08 00000001
r 80000020 1 09 00000000
r 80000024 1 0a 000000fa
r 80000028 1 0b fffffffd
r 8000002c 1 0c 0000000d
r 80000030 1 00 0000000c
r 80000034 1 0d 00000005
r 80000038 1 0e 00001000
r 8000003c 1 0f 8000003c
r 80000040 0 00 00000000
r 80000044 0 00 00000000
r 80000048 0 00 00000000
r 8000004c 1 10 fffffffd
r 80000050 1 11 fffffffd
r 80000054 1 12 000000ff
r 80000058 1 13 fffffffd
r 8000005c 1 14 00000544
r 80000060 1 15 80706050
r 80000064 0 00 00000000
r 8000006c 0 00 00000000
r 80000070 0 00 00000000
r 80000078 0 00 00000000
r 8000007c 0 00 00000000
r 80000080 0 00 00000000
r 80000088 1 17 8000008c
r 80000090 1 18 80000090
r 80000094 1 19 80000098
h 1 0
s
i 00900093
i 00108133
i ffffffff
r 80000000 1 01 00000009
r 80000004 1 02 00000012
h 1 1
